// File: rtl/arb_pkg.sv
//====================================================================
// arbitration types shared by the queue block, arbiter and hop stage
// client ids are 3 bits wide, so at most eight links per output port
//====================================================================
package arb_pkg;

    //====================================================================
    // limits
    //====================================================================
    localparam int MAX_CLIENTS = 8; // upper bound for NUM_CLIENTS

    // queue index, also stamped into the outgoing src_port field
    typedef logic [2:0] t_client_id;

    //====================================================================
    // arbiter decision handed to the hop stage
    //====================================================================
    typedef struct packed {
        logic       valid; // register holds a granted transaction
        t_client_id id;    // link that won
    } t_winner;            // 4 bits

    // the decision and the payload travel on separate ports because
    // the payload type is a parameter of the arbiter

endpackage : arb_pkg

// File: rtl/router_pkg.sv
//====================================================================
// tile transaction format, 28 bits, as seen on every link of the tile
// hop count is 4 bits and never wraps below zero
//====================================================================
package router_pkg;

    //====================================================================
    // hop count
    //====================================================================
    // remaining hops to destination, saturates at zero in the hop stage
    typedef logic [3:0] t_hop_count;

    //====================================================================
    // one transaction on a link
    //====================================================================
    typedef struct packed {
        logic [2:0]          dest_x;   // destination column
        logic [2:0]          dest_y;   // destination row
        t_hop_count          hops;     // decremented once per tile
        arb_pkg::t_client_id src_port; // link it entered on, set at output
        logic [14:0]         payload;  // opaque to the router
    } t_tile_trans;

    // field order is fixed, neighbour tiles unpack the same layout
    // msb first: dest_x dest_y hops src_port payload

    // route computation fills dest_x/dest_y upstream
    // this port never looks at them

endpackage : router_pkg

// File: rtl/fifo.sv
//====================================================================
// FIFO_DEPTH must be a power of two and at least 2
// payload_t must be a packed type, head is read combinationally
//====================================================================
`timescale 1ns/1ns

module fifo #(
    parameter type payload_t  = logic [7:0],
    parameter int  FIFO_DEPTH = 4
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     push,      // write strobe
    input  payload_t push_data,
    input  logic     pop,       // advance head on this edge
    output payload_t pop_data,  // head entry, valid while !empty
    output logic     full,
    output logic     empty
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = PTR_W + 1; // count runs 0..FIFO_DEPTH

    // depth sanity at elaboration
    if (FIFO_DEPTH < 2 || (FIFO_DEPTH & (FIFO_DEPTH - 1)) != 0) begin : g_bad_depth
        $error("fifo: FIFO_DEPTH must be a power of two >= 2");
    end

    payload_t         mem [FIFO_DEPTH]; // storage, no reset
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    assign do_pop  = pop && !empty;          // pop on empty ignored
    assign do_push = push && (!full || pop); // full + pop frees a slot

    assign full     = (count == CNT_W'(FIFO_DEPTH));
    assign empty    = (count == '0);
    assign pop_data = mem[rd_ptr];

    //====================================================================
    // pointers and occupancy
    //====================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + PTR_W'(1); // wraps, power of two
            if (do_pop)  rd_ptr <= rd_ptr + PTR_W'(1);
            case ({do_push, do_pop})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count; // idle or push+pop
            endcase
        end
    end

    // data write
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule : fifo

// File: rtl/rr_arbiter.sv
//====================================================================
// round-robin over NUM_CLIENTS queues, grant and pop on the same edge
// winner register loads only when empty or when advance is high
//====================================================================
`timescale 1ns/1ns

module rr_arbiter #(
    parameter type payload_t   = logic [7:0],
    parameter int  NUM_CLIENTS = 4
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [NUM_CLIENTS-1:0]         candidate_valid, // queue not empty
    input  var payload_t [NUM_CLIENTS-1:0] candidate,       // queue heads
    input  logic                           advance,         // hop stage accepts
    output logic [NUM_CLIENTS-1:0]         pop,             // one-hot or zero
    output arb_pkg::t_winner               winner,
    output payload_t                       winner_data
);

    import arb_pkg::*;

    localparam int ID_W = $clog2(NUM_CLIENTS);

    logic [ID_W-1:0] last_grant; // client granted most recently
    logic [ID_W-1:0] grant_idx;
    logic            grant_found;
    logic            load;

    // register free, or its content moves on this edge
    assign load = !winner.valid || advance;

    //====================================================================
    // next requester after last_grant, circular order
    //====================================================================
    always_comb begin
        logic [ID_W-1:0] cand_idx;
        grant_found = 1'b0;
        grant_idx   = last_grant;
        cand_idx    = '0;
        for (int i = 1; i <= NUM_CLIENTS; i++) begin
            cand_idx = ID_W'((int'(last_grant) + i) % NUM_CLIENTS);
            if (!grant_found && candidate_valid[cand_idx]) begin
                grant_found = 1'b1; // first hit wins
                grant_idx   = cand_idx;
            end
        end
    end

    // pop only when the register really takes the head
    always_comb begin
        pop = '0;
        if (load && grant_found) begin
            pop[grant_idx] = 1'b1;
        end
    end

    //====================================================================
    // winner register and rotation pointer
    //====================================================================
    always_ff @(posedge clk) begin
        if (rst) begin
            winner     <= '0;
            last_grant <= ID_W'(NUM_CLIENTS - 1); // so queue 0 goes first
        end else if (load) begin
            winner.valid <= grant_found; // invalid when nobody asks
            winner.id    <= t_client_id'(grant_idx);
            if (grant_found) begin
                last_grant <= grant_idx;
            end
        end
    end

    // payload follows the winner, no reset
    always_ff @(posedge clk) begin
        if (load && grant_found) begin
            winner_data <= candidate[grant_idx];
        end
    end

endmodule : rr_arbiter

// File: rtl/fifo_arb.sv
//====================================================================
// one queue per neighbour link feeding a round-robin arbiter
// NUM_CLIENTS 2..8, alloc_ready is simply queue not full
//====================================================================
`timescale 1ns/1ns

module fifo_arb #(
    parameter int NUM_CLIENTS = 4,
    parameter int FIFO_DEPTH  = 4
) (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic [NUM_CLIENTS-1:0]                    alloc_valid, // push strobes
    input  var router_pkg::t_tile_trans [NUM_CLIENTS-1:0] alloc_req,
    output logic [NUM_CLIENTS-1:0]                    alloc_ready, // queue not full
    input  logic                                      advance,     // from hop stage
    output arb_pkg::t_winner                          winner,
    output router_pkg::t_tile_trans                   winner_data
);

    import router_pkg::*;
    import arb_pkg::*;

    // link count limited by the 3-bit client id
    if (NUM_CLIENTS < 2 || NUM_CLIENTS > MAX_CLIENTS) begin : g_bad_clients
        $error("fifo_arb: NUM_CLIENTS must be in 2..MAX_CLIENTS");
    end

    t_tile_trans [NUM_CLIENTS-1:0] head_data; // queue heads, arbiter candidates
    logic [NUM_CLIENTS-1:0]        full;
    logic [NUM_CLIENTS-1:0]        empty;
    logic [NUM_CLIENTS-1:0]        fifo_pop;  // one-hot from arbiter

    assign alloc_ready = ~full;

    //====================================================================
    // per-link queues
    //====================================================================
    for (genvar i = 0; i < NUM_CLIENTS; i++) begin : gen_fifo
        fifo #(
            .payload_t  (t_tile_trans),
            .FIFO_DEPTH (FIFO_DEPTH)
        ) u_fifo (
            .clk       (clk),
            .rst       (rst),
            .push      (alloc_valid[i]), // dropped by fifo if full
            .push_data (alloc_req[i]),
            .pop       (fifo_pop[i]),
            .pop_data  (head_data[i]),
            .full      (full[i]),
            .empty     (empty[i])
        );
    end

    // arbiter sees not-empty as the request
    rr_arbiter #(
        .payload_t   (t_tile_trans),
        .NUM_CLIENTS (NUM_CLIENTS)
    ) u_arb (
        .clk             (clk),
        .rst             (rst),
        .candidate_valid (~empty),
        .candidate       (head_data),
        .advance         (advance),
        .pop             (fifo_pop),
        .winner          (winner),
        .winner_data     (winner_data)
    );

endmodule : fifo_arb

// File: rtl/hop_update.sv
//====================================================================
// output register toward the next tile, holds while out_ready is low
// hops saturate at zero, src_port is overwritten with the winner id
//====================================================================
`timescale 1ns/1ns

module hop_update (
    input  logic                    clk,
    input  logic                    rst,
    input  arb_pkg::t_winner        winner,
    input  router_pkg::t_tile_trans winner_data,
    output logic                    advance,   // register accepts this edge
    output logic                    out_valid,
    output router_pkg::t_tile_trans out_req,
    input  logic                    out_ready  // level from next tile
);

    import router_pkg::*;

    t_tile_trans next_trans; // rewritten transaction

    // empty slot, or current content leaves this edge
    assign advance = !out_valid || out_ready;

    //====================================================================
    // hop decrement and source stamp
    //====================================================================
    always_comb begin
        next_trans = winner_data;
        if (winner_data.hops != '0) begin
            next_trans.hops = winner_data.hops - t_hop_count'(1);
        end else begin
            next_trans.hops = '0; // already at destination distance 0
        end
        next_trans.src_port = winner.id;
    end

    // valid flag, cleared on reset
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (advance) begin
            out_valid <= winner.valid; // bubble in gives bubble out
        end
    end

    // transaction register, held under back-pressure
    always_ff @(posedge clk) begin
        if (advance && winner.valid) begin
            out_req <= next_trans;
        end
    end

endmodule : hop_update

// File: rtl/router_out_port.sv
//====================================================================
// north output port: link queues, round-robin arbiter, hop stage
// push to out_valid is two edges with idle stages and out_ready high
//====================================================================
`timescale 1ns/1ns

module router_out_port #(
    parameter int NUM_CLIENTS = 4, // 2..8 links
    parameter int FIFO_DEPTH  = 4  // power of two
) (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic [NUM_CLIENTS-1:0]                    alloc_valid,
    input  var router_pkg::t_tile_trans [NUM_CLIENTS-1:0] alloc_req,
    output logic [NUM_CLIENTS-1:0]                    alloc_ready,
    output logic                                      out_valid,
    output router_pkg::t_tile_trans                   out_req,
    input  logic                                      out_ready
);

    import router_pkg::*;
    import arb_pkg::*;

    //====================================================================
    // stage to stage wires
    //====================================================================
    t_winner     winner;      // arbiter decision
    t_tile_trans winner_data; // granted transaction
    logic        advance;     // hop stage will take it

    // queues + arbiter, stages 1 and 2
    fifo_arb #(
        .NUM_CLIENTS (NUM_CLIENTS),
        .FIFO_DEPTH  (FIFO_DEPTH)
    ) u_fifo_arb (
        .clk         (clk),
        .rst         (rst),
        .alloc_valid (alloc_valid),
        .alloc_req   (alloc_req),
        .alloc_ready (alloc_ready),
        .advance     (advance),
        .winner      (winner),
        .winner_data (winner_data)
    );

    // hop stage, stage 3
    hop_update u_hop_update (
        .clk         (clk),
        .rst         (rst),
        .winner      (winner),
        .winner_data (winner_data),
        .advance     (advance),
        .out_valid   (out_valid),
        .out_req     (out_req),
        .out_ready   (out_ready)
    );

endmodule : router_out_port

// File: tests/tb_assertions.sv
//====================================================================
// bound into router_out_port, pop is taken from the arbiter inside
//====================================================================
`timescale 1ns/1ns

module handshake_assertions #(
    parameter int NUM_CLIENTS = 4
) (
    input logic                    clk,
    input logic                    rst,
    input logic [NUM_CLIENTS-1:0]  alloc_valid,
    input logic [NUM_CLIENTS-1:0]  alloc_ready,
    input logic [NUM_CLIENTS-1:0]  pop,       // arbiter pop vector
    input logic                    out_valid,
    input router_pkg::t_tile_trans out_req,
    input logic                    out_ready
);

    int failures = 0; // read by tb_top at the end

    // stalled output holds
    a_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_req))
        else begin
            failures++;
            $error("out_req or out_valid changed while the next tile was not ready");
        end

    a_no_full_push: assert property (@(posedge clk) disable iff (rst)
        (alloc_valid & ~alloc_ready) == '0)
        else begin
            failures++;
            $error("push strobe reached a full queue");
        end

    a_pop_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(pop))
        else begin
            failures++;
            $error("arbiter popped more than one queue at once");
        end

    // no disable here, reset itself is the trigger
    a_reset_idle: assert property (@(posedge clk) rst |=> !out_valid)
        else begin
            failures++;
            $error("out_valid high right after reset");
        end

endmodule : handshake_assertions

bind router_out_port handshake_assertions #(
    .NUM_CLIENTS (NUM_CLIENTS)
) u_handshake_assertions (
    .clk         (clk),
    .rst         (rst),
    .alloc_valid (alloc_valid),
    .alloc_ready (alloc_ready),
    .pop         (u_fifo_arb.fifo_pop),
    .out_valid   (out_valid),
    .out_req     (out_req),
    .out_ready   (out_ready)
);

// File: tests/tb_checker.sv
//====================================================================
// scoreboard, one model queue per link, phase codes follow tb_top
//====================================================================
`timescale 1ns/1ns

module scoreboard #(
    parameter int NUM_CLIENTS = 4,
    parameter int FIFO_DEPTH  = 4
) (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic [2:0]                                phase,
    input  logic [NUM_CLIENTS-1:0]                    alloc_valid,
    input  router_pkg::t_tile_trans [NUM_CLIENTS-1:0] alloc_req,
    input  logic [NUM_CLIENTS-1:0]                    alloc_ready,
    input  logic                                      out_valid,
    input  router_pkg::t_tile_trans                   out_req,
    input  logic                                      out_ready,
    output int                                        error_count,
    output int                                        check_count
);

    import router_pkg::*;

    localparam logic [2:0] PH_LATENCY = 3'd1;
    localparam logic [2:0] PH_RANDOM  = 3'd2;
    localparam logic [2:0] PH_STALL   = 3'd3;
    localparam logic [2:0] PH_DRAIN   = 3'd4;
    localparam logic [2:0] PH_BURST   = 3'd5;
    localparam logic [2:0] PH_DONE    = 3'd6;

    t_tile_trans model_q  [NUM_CLIENTS][$]; // expected outputs per link
    int          push_cyc [NUM_CLIENTS][$]; // push edge of each entry
    int          cyc;
    int          pending;
    int          last_id;                   // previous burst src_port
    bit          prev_stall;
    bit          lat_seen;
    bit          final_seen;
    t_tile_trans prev_req;
    logic [2:0]  prev_phase;

    function automatic string test_name(input logic [2:0] p);
        case (p)
            PH_LATENCY: return "latency";
            PH_RANDOM:  return "random";
            PH_STALL:   return "stall";
            PH_DRAIN:   return "drain";
            PH_BURST:   return "burst";
            PH_DONE:    return "final";
            default:    return "reset";
        endcase
    endfunction

    // one hop less, never below zero; src_port becomes the link
    function automatic t_tile_trans expected_out(input t_tile_trans t, input int link);
        t_tile_trans e;
        e          = t;
        e.hops     = (t.hops == '0) ? '0 : t.hops - 4'd1;
        e.src_port = arb_pkg::t_client_id'(link);
        return e;
    endfunction

    task automatic compare(input string what, input logic [31:0] want, input logic [31:0] got);
        check_count++;
        if (want !== got) begin
            error_count++;
            $display("[FAIL] %s: %s expected %0h actual %0h", test_name(phase), what, want, got);
        end
    endtask

    task automatic report_problem(input string msg);
        error_count++;
        $display("ERROR in %s: %s", test_name(phase), msg);
    endtask

    //====================================================================
    // sampled on every rising edge, inputs settle well before it
    //====================================================================
    always @(posedge clk) begin
        int          id;
        int          pc;
        t_tile_trans want;
        if (rst) begin
            cyc         = 0;
            last_id     = -1;
            prev_stall  = 1'b0;
            lat_seen    = 1'b0;
            final_seen  = 1'b0;
            prev_phase  = '0;
            error_count = 0;
            check_count = 0;
        end else begin
            cyc++;
            // the single push must have come out before traffic starts
            if (prev_phase == PH_LATENCY && phase != PH_LATENCY && !lat_seen) begin
                report_problem("single push never reached the output in time");
            end
            // stall over: queues full plus both stage registers loaded
            if (prev_phase == PH_STALL && phase != PH_STALL) begin
                pending = 0;
                for (int i = 0; i < NUM_CLIENTS; i++) begin
                    pending += model_q[i].size();
                end
                compare("alloc_ready after stall", '0, alloc_ready);
                compare("entries held in port", NUM_CLIENTS * FIFO_DEPTH + 2, pending);
            end
            if (prev_stall) begin
                compare("out_valid while stalled", 1, out_valid);
                compare("out_req while stalled", prev_req, out_req);
            end
            if (out_valid && out_ready) begin
                id = int'(out_req.src_port);
                if (id >= NUM_CLIENTS || model_q[id].size() == 0) begin
                    report_problem($sformatf("output on src_port %0d matches no push", id));
                end else begin
                    want = model_q[id].pop_front();
                    pc   = push_cyc[id].pop_front();
                    compare($sformatf("link %0d transaction", id), want, out_req);
                    if (phase == PH_LATENCY && !lat_seen) begin
                        lat_seen = 1'b1;
                        compare("edges from push to out_valid", 2, cyc - 1 - pc);
                    end
                    if (phase == PH_BURST) begin
                        if (last_id >= 0) begin
                            compare("src_port rotation", (last_id + 1) % NUM_CLIENTS, id);
                        end
                        last_id = id;
                    end
                end
            end
            for (int i = 0; i < NUM_CLIENTS; i++) begin
                if (alloc_valid[i] && alloc_ready[i]) begin
                    model_q[i].push_back(expected_out(alloc_req[i], i));
                    push_cyc[i].push_back(cyc);
                end
            end
            if (phase == PH_DONE && !final_seen) begin
                final_seen = 1'b1;
                for (int i = 0; i < NUM_CLIENTS; i++) begin
                    if (model_q[i].size() != 0) begin
                        report_problem($sformatf("link %0d lost %0d accepted pushes",
                                                 i, model_q[i].size()));
                    end
                end
            end
            prev_stall = out_valid && !out_ready;
            prev_req   = out_req;
            prev_phase = phase;
        end
    end

endmodule : scoreboard

// File: tests/tb_top.sv
//====================================================================
// four links, depth 4, LFSR traffic; inputs change 1 ns after the edge
//====================================================================
`timescale 1ns/1ns

module tb_top;

    import router_pkg::*;

    localparam int NUM_CLIENTS   = 4;
    localparam int FIFO_DEPTH    = 4;
    localparam int CLK_PERIOD    = 100;
    localparam int RESET_CYCLES  = 8;
    localparam int RANDOM_CYCLES = 400;
    localparam int STALL_CYCLES  = 40;
    localparam int PHASE_LIMIT   = 200; // generous bound for drain or fill
    // reset + fixed phases + four open-ended waits + slack
    localparam int RUN_CYCLES = RESET_CYCLES + RANDOM_CYCLES + STALL_CYCLES
                              + 4 * PHASE_LIMIT + 100;

    // phase codes, scoreboard uses the same
    localparam logic [2:0] PH_RESET   = 3'd0;
    localparam logic [2:0] PH_LATENCY = 3'd1;
    localparam logic [2:0] PH_RANDOM  = 3'd2;
    localparam logic [2:0] PH_STALL   = 3'd3;
    localparam logic [2:0] PH_DRAIN   = 3'd4;
    localparam logic [2:0] PH_BURST   = 3'd5;
    localparam logic [2:0] PH_DONE    = 3'd6;

    logic                          clk;
    logic                          rst;
    logic [NUM_CLIENTS-1:0]        alloc_valid;
    t_tile_trans [NUM_CLIENTS-1:0] alloc_req;
    logic [NUM_CLIENTS-1:0]        alloc_ready;
    logic                          out_valid;
    t_tile_trans                   out_req;
    logic                          out_ready;
    logic [2:0]                    phase;
    logic [31:0]                   lfsr;
    int                            error_count;
    int                            check_count;

    router_out_port #(
        .NUM_CLIENTS (NUM_CLIENTS),
        .FIFO_DEPTH  (FIFO_DEPTH)
    ) UUT (.*);

    scoreboard #(
        .NUM_CLIENTS (NUM_CLIENTS),
        .FIFO_DEPTH  (FIFO_DEPTH)
    ) u_scoreboard (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int nbits, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr  = lfsr_next(lfsr); // one step per bit
            value = {value[30:0], lfsr[0]};
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // pushes only where the queue has room, random fields incl. src_port
    task automatic drive_links(input bit push_all);
        logic [31:0] v;
        for (int i = 0; i < NUM_CLIENTS; i++) begin
            take_bits(1, v);
            alloc_valid[i] = alloc_ready[i] && (push_all || v[0]);
            take_bits(28, v);
            alloc_req[i] = v[27:0];
        end
    endtask

    // no pushes, next tile ready; done once out_valid stays low
    task automatic wait_idle();
        int quiet;
        quiet       = 0;
        alloc_valid = '0;
        out_ready   = 1'b1;
        while (quiet < 4) begin
            next_cycle();
            quiet = out_valid ? 0 : quiet + 1;
        end
    endtask

    //====================================================================
    // test sequence
    //====================================================================
    initial begin
        logic [31:0] v;
        lfsr        = 32'he02b_e9e0;
        rst         = 1'b1;
        alloc_valid = '0;
        alloc_req   = '0;
        out_ready   = 1'b0;
        phase       = PH_RESET;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;

        phase     = PH_LATENCY; // one push into empty stages
        out_ready = 1'b1;
        next_cycle();
        take_bits(28, v);
        alloc_req[0]   = v[27:0];
        alloc_valid[0] = 1'b1;
        next_cycle();
        wait_idle();

        phase = PH_RANDOM;
        repeat (RANDOM_CYCLES) begin
            drive_links(1'b0);
            take_bits(2, v);
            out_ready = (v[1:0] != 2'b00); // ready 3 cycles in 4
            next_cycle();
        end

        phase     = PH_STALL; // fill everything behind a dead link
        out_ready = 1'b0;
        repeat (STALL_CYCLES) begin
            drive_links(1'b1);
            next_cycle();
        end
        phase = PH_DRAIN;
        wait_idle();

        phase     = PH_BURST; // pre-fill all queues, then release
        out_ready = 1'b0;
        while (alloc_ready != '0) begin
            drive_links(1'b1);
            next_cycle();
        end
        wait_idle();

        phase = PH_DONE;
        repeat (2) next_cycle();
        $display("checks: %0d  errors: %0d  assertion failures: %0d",
                 check_count, error_count, UUT.u_handshake_assertions.failures);
        if (error_count == 0 && UUT.u_handshake_assertions.failures == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(RUN_CYCLES * CLK_PERIOD);
        $display("watchdog: run did not finish within %0d cycles", RUN_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule : tb_top

// File: files.f
rtl/arb_pkg.sv
rtl/router_pkg.sv
rtl/fifo.sv
rtl/rr_arbiter.sv
rtl/fifo_arb.sv
rtl/hop_update.sv
rtl/router_out_port.sv
tests/tb_assertions.sv
tests/tb_checker.sv
tests/tb_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the router output port testbench with Verilator, run it, scan the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f files.f -o sim_tb \
    > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_tb +verilator+error+limit+1000 > "$LOG" 2>&1 || echo "simulator exit status was non-zero"
grep -qF "*** TEST FAILED ***" "$LOG" && { echo "simulation failed, see $LOG"; exit 1; }
grep -qF "*** TEST PASSED ***" "$LOG" || { echo "run ended without a result, see $LOG"; exit 1; }
echo "simulation passed"
